// File: all.f
verilog/fu_pkg.sv
verilog/fu_issue_ctrl.sv
verilog/int_alu.sv
verilog/br_alu.sv
verilog/mult_pipe.sv
verilog/cmpl_queue.sv
verilog/fu_cluster.sv
testbench/tb_fu_cluster.sv

// File: testbench/tb_fu_cluster.sv
`timescale 1ns/1ps

module tb_fu_cluster;

	localparam int MAX_ROWS = 1 << fu_pkg::ROB_IDX_W; // One row per ROB index

	logic clk;
	logic rst;
	fu_pkg::fu_sel_e fu_sel_i;
	logic [fu_pkg::XLEN-1:0] pc_i, ra_value_i, rb_value_i;
	logic [fu_pkg::INST_W-1:0] ir_i;
	logic [fu_pkg::PRF_IDX_W-1:0] dest_tag_i;
	logic [fu_pkg::ROB_IDX_W-1:0] rob_idx_i;
	logic wb_valid_o, preg_wr_en_o, br_taken_o, credit_o, cdb_valid_o;
	logic [fu_pkg::PRF_IDX_W-1:0] preg_wr_idx_o, cdb_tag_o;
	logic [fu_pkg::XLEN-1:0] preg_wr_value_o, br_target_o;
	logic [fu_pkg::ROB_IDX_W-1:0] rob_idx_o;

	fu_pkg::fu_sel_e row_sel [MAX_ROWS];
	logic [fu_pkg::INST_W-1:0] row_ir [MAX_ROWS];
	logic [fu_pkg::XLEN-1:0] row_ra [MAX_ROWS];
	logic [fu_pkg::XLEN-1:0] row_rb [MAX_ROWS];
	logic [fu_pkg::XLEN-1:0] row_pc [MAX_ROWS];
	logic [fu_pkg::PRF_IDX_W-1:0] row_tag [MAX_ROWS];
	logic [fu_pkg::XLEN-1:0] row_val [MAX_ROWS]; // Target for branch rows
	logic row_taken [MAX_ROWS];
	int row_gap [MAX_ROWS]; // Idle cycles after the row or -1 for a random gap
	logic pending [MAX_ROWS];
	int n_rows = 0;
	int credits;
	int retired;
	int seed;

	fu_cluster dut0 (
		.clk, .rst, .fu_sel_i, .pc_i, .ir_i, .ra_value_i, .rb_value_i, .dest_tag_i, .rob_idx_i,
		.wb_valid_o, .preg_wr_en_o, .preg_wr_idx_o, .preg_wr_value_o, .rob_idx_o,
		.br_taken_o, .br_target_o, .credit_o, .cdb_valid_o, .cdb_tag_o
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic alu_row(input logic [6:0] func, input logic [63:0] ra, input logic [63:0] rb,
			input logic [5:0] tag, input logic [63:0] val, input int gap);
		row_sel[n_rows] = fu_pkg::FU_SEL_ALU;
		row_ir[n_rows] = {6'h10, 14'd0, func, 5'd0};
		row_ra[n_rows] = ra;
		row_rb[n_rows] = rb;
		row_pc[n_rows] = '0;
		row_tag[n_rows] = tag;
		row_val[n_rows] = val;
		row_taken[n_rows] = 1'b0;
		row_gap[n_rows] = gap;
		pending[n_rows] = 1'b0;
		n_rows++;
	endtask

	task automatic mul_row(input logic [63:0] ra, input logic [63:0] rb, input logic [5:0] tag,
			input logic [63:0] val, input int gap);
		alu_row(fu_pkg::FUNC_ADDQ, ra, rb, tag, val, gap);
		row_sel[n_rows-1] = fu_pkg::FU_SEL_MULT;
	endtask

	task automatic br_row(input logic [5:0] opc, input logic [63:0] ra, input logic [63:0] pc,
			input logic [20:0] disp, input logic taken, input logic [63:0] target, input int gap);
		alu_row(7'h00, ra, '0, '0, target, gap);
		row_sel[n_rows-1] = fu_pkg::FU_SEL_BR;
		row_ir[n_rows-1] = {opc, 5'd0, disp};
		row_pc[n_rows-1] = pc;
		row_taken[n_rows-1] = taken;
	endtask

	task automatic issue_row(input int r);
		fu_sel_i <= row_sel[r];
		pc_i <= row_pc[r];
		ir_i <= row_ir[r];
		ra_value_i <= row_ra[r];
		rb_value_i <= row_rb[r];
		dest_tag_i <= row_tag[r];
		rob_idx_i <= fu_pkg::ROB_IDX_W'(r);
		pending[r] = 1'b1;
	endtask

	task automatic check_retire();
		int idx;
		idx = rob_idx_o;
		if (idx >= n_rows || !pending[idx]) begin
			$display("Retire of ROB index %0d which has no pending row", idx);
			abort_run();
		end
		if (row_sel[idx] == fu_pkg::FU_SEL_BR) begin
			compare_value("preg_wr_en_o", preg_wr_en_o, 1'b0);
			compare_value("br_taken_o", br_taken_o, row_taken[idx]);
			compare_value("br_target_o", br_target_o, row_val[idx]);
		end else begin
			compare_value("preg_wr_en_o", preg_wr_en_o, 1'b1);
			compare_value("preg_wr_idx_o", preg_wr_idx_o, row_tag[idx]);
			compare_value("preg_wr_value_o", preg_wr_value_o, row_val[idx]);
		end
		compare_value("credit_o", credit_o, 1'b1); // One credit per retire
		pending[idx] = 1'b0;
		retired++;
		credits++;
		if (credits > fu_pkg::CQ_DEPTH) begin
			$display("Credit count rose above the queue depth");
			abort_run();
		end
	endtask

	initial begin : monitor
		logic prev_wr_en;
		logic [fu_pkg::PRF_IDX_W-1:0] prev_wr_idx;
		prev_wr_en = 1'b0;
		prev_wr_idx = '0;
		forever begin
			@(negedge clk);
			if (rst) begin
				prev_wr_en = 1'b0;
			end else begin
				compare_value("cdb_valid_o", cdb_valid_o, prev_wr_en);
				if (prev_wr_en)
					compare_value("cdb_tag_o", cdb_tag_o, prev_wr_idx);
				if (wb_valid_o)
					check_retire();
				else
					compare_value("credit_o", credit_o, 1'b0); // No credit without a retire
				prev_wr_en = preg_wr_en_o;
				prev_wr_idx = preg_wr_idx_o;
			end
		end
	end

	initial begin : watchdog
		@(negedge rst);
		repeat (n_rows * 20) @(posedge clk);
		$display("Timeout with %0d of %0d rows retired", retired, n_rows);
		abort_run();
	end

	initial begin : driver
		int r;
		int gap;
		seed = 86898;
		credits = fu_pkg::CQ_DEPTH;
		retired = 0;
		rst = 1'b1;
		fu_sel_i = fu_pkg::FU_SEL_NONE;
		pc_i = '0;
		ir_i = '0;
		ra_value_i = '0;
		rb_value_i = '0;
		dest_tag_i = '0;
		rob_idx_i = '0;
		alu_row(fu_pkg::FUNC_ADDQ, 5, 7, 1, 64'hc, 0);
		alu_row(fu_pkg::FUNC_SUBQ, 3, 5, 2, 64'hffff_ffff_ffff_fffe, 0);
		alu_row(fu_pkg::FUNC_AND, 64'hf0f0, 64'hff00, 3, 64'hf000, 0);
		alu_row(fu_pkg::FUNC_BIS, 64'hf0f0, 64'h0f0f, 4, 64'hffff, 0);
		alu_row(fu_pkg::FUNC_XOR, 64'hff, 64'h0f, 5, 64'hf0, -1);
		alu_row(fu_pkg::FUNC_SLL, 1, 64'h44, 6, 64'h10, -1); // Only low 6 bits shift
		alu_row(fu_pkg::FUNC_SRL, 64'h8000_0000_0000_0000, 63, 7, 1, -1);
		alu_row(fu_pkg::FUNC_CMPEQ, 9, 9, 8, 1, -1);
		alu_row(fu_pkg::FUNC_CMPULT, 3, 64'hffff_ffff_ffff_ffff, 9, 1, 4);
		mul_row(3, 5, 10, 64'hf, 0); // Third ALU row below lands with this product
		alu_row(fu_pkg::FUNC_ADDQ, 1, 1, 11, 2, 0);
		alu_row(fu_pkg::FUNC_CMPULT, 7, 3, 12, 0, 0);
		alu_row(7'h7f, 64'h10, 64'h20, 13, 64'h30, -1);
		mul_row(64'h1_0000_0001, 64'h1_0000_0001, 14, 64'h2_0000_0001, 0);
		mul_row(64'hffff_ffff_ffff_ffff, 64'h0001_0001_0001_0002, 15,
			64'hfffe_fffe_fffe_fffe, -1); // Every slice of opb is nonzero
		br_row(fu_pkg::OPC_BR, 0, 64'h1000, 21'h4, 1'b1, 64'h1010, 0);
		br_row(fu_pkg::OPC_BEQ, 0, 64'h2000, 21'h1ffffe, 1'b1, 64'h1ff8, 0);
		br_row(fu_pkg::OPC_BNE, 0, 64'h3000, 21'h1, 1'b0, 64'h3004, -1);
		br_row(fu_pkg::OPC_BLT, 64'hffff_ffff_ffff_ffff, 64'h4000, 21'h10, 1'b1, 64'h4040, 0);
		br_row(fu_pkg::OPC_BGE, 64'hffff_ffff_ffff_ffff, 64'h5000, 21'h0, 1'b0, 64'h5000, 0);
		alu_row(fu_pkg::FUNC_ADDQ, 64'hffff_ffff_ffff_ffff, 1, 16, 0, 0);
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		compare_value("wb_valid_o", wb_valid_o, 1'b0);
		compare_value("credit_o", credit_o, 1'b0);
		compare_value("cdb_valid_o", cdb_valid_o, 1'b0);
		// Memory selects carry no work and must never retire
		@(posedge clk);
		fu_sel_i <= fu_pkg::FU_SEL_LOAD;
		ir_i <= 32'hdead_beef;
		rob_idx_i <= '1;
		@(posedge clk);
		fu_sel_i <= fu_pkg::FU_SEL_STORE;
		@(posedge clk);
		fu_sel_i <= fu_pkg::FU_SEL_NONE;
		repeat (8) @(posedge clk);
		compare_value("credits", credits, fu_pkg::CQ_DEPTH);
		r = 0;
		gap = 0;
		while (r < n_rows) begin
			@(posedge clk);
			if (gap > 0) begin
				fu_sel_i <= fu_pkg::FU_SEL_NONE;
				gap--;
			end else if (credits > 0) begin
				issue_row(r);
				credits--;
				gap = (row_gap[r] < 0) ? {$random(seed)} % 4 : row_gap[r];
				r++;
			end else begin
				fu_sel_i <= fu_pkg::FU_SEL_NONE; // Out of credits
			end
		end
		@(posedge clk);
		fu_sel_i <= fu_pkg::FU_SEL_NONE;
		while (retired < n_rows) @(negedge clk);
		repeat (3) @(negedge clk); // Last CDB broadcast and no stray retires
		if (credits == fu_pkg::CQ_DEPTH && retired == n_rows) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("End of run with %0d credits and %0d retires", credits, retired);
			abort_run();
		end
	end

endmodule

// File: verilog/br_alu.sv
`timescale 1ns/1ps

module br_alu (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start_i,
	input  fu_pkg::br_op_e                op_i,
	input  logic [fu_pkg::XLEN-1:0]       npc_i,
	input  logic [fu_pkg::XLEN-1:0]       opa_i,
	input  logic [fu_pkg::DISP_W-1:0]     disp_i,
	input  logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_i,
	output logic                          done_o,
	output logic                          taken_o,
	output logic [fu_pkg::XLEN-1:0]       target_o,
	output logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_o
);

	logic taken;
	logic [fu_pkg::XLEN-1:0] disp_ext;

	// Word displacement, sign extended and scaled by four
	assign disp_ext = {{(fu_pkg::XLEN-fu_pkg::DISP_W-2){disp_i[fu_pkg::DISP_W-1]}}, disp_i, 2'b00};

	always_comb begin
		case (op_i)
			fu_pkg::BR_ALWAYS: taken = 1'b1;
			fu_pkg::BR_EQ: taken = (opa_i == '0);
			fu_pkg::BR_NE: taken = (opa_i != '0);
			fu_pkg::BR_LT: taken = $signed(opa_i) < 0;
			fu_pkg::BR_GE: taken = $signed(opa_i) >= 0;
			default: taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
		end
	end

	always_ff @(posedge clk) begin
		taken_o <= taken;
		target_o <= npc_i + disp_ext;
		rob_idx_o <= rob_idx_i;
	end

endmodule

// File: verilog/cmpl_queue.sv
`timescale 1ns/1ps

module cmpl_queue (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          sh_valid_i,
	input  logic                          sh_is_br_i,
	input  logic [fu_pkg::XLEN-1:0]       sh_value_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  sh_tag_i,
	input  logic [fu_pkg::ROB_IDX_W-1:0]  sh_rob_i,
	input  logic                          sh_taken_i,
	input  logic                          mul_valid_i,
	input  logic [fu_pkg::XLEN-1:0]       mul_value_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  mul_tag_i,
	input  logic [fu_pkg::ROB_IDX_W-1:0]  mul_rob_i,
	output logic                          wb_valid_o,
	output logic                          preg_wr_en_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  preg_wr_idx_o,
	output logic [fu_pkg::XLEN-1:0]       preg_wr_value_o,
	output logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_o,
	output logic                          br_taken_o,
	output logic [fu_pkg::XLEN-1:0]       br_target_o,
	output logic                          credit_o,
	output logic                          cdb_valid_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  cdb_tag_o
);

	logic [fu_pkg::XLEN-1:0] q_value [fu_pkg::CQ_DEPTH]; // Target for branches
	logic [fu_pkg::PRF_IDX_W-1:0] q_tag [fu_pkg::CQ_DEPTH];
	logic [fu_pkg::ROB_IDX_W-1:0] q_rob [fu_pkg::CQ_DEPTH];
	logic [fu_pkg::CQ_DEPTH-1:0] q_is_br;
	logic [fu_pkg::CQ_DEPTH-1:0] q_taken;

	logic [fu_pkg::CQ_PTR_W-1:0] head_q, tail_q, mul_ptr;
	logic [fu_pkg::CQ_PTR_W:0] count_q;
	logic [1:0] n_wr;

	assign mul_ptr = sh_valid_i ? tail_q + 1'b1 : tail_q; // Short result goes first
	assign n_wr = {1'b0, sh_valid_i} + {1'b0, mul_valid_i};

	always_ff @(posedge clk) begin
		if (sh_valid_i) begin
			q_value[tail_q] <= sh_value_i;
			q_tag[tail_q] <= sh_tag_i;
			q_rob[tail_q] <= sh_rob_i;
			q_is_br[tail_q] <= sh_is_br_i;
			q_taken[tail_q] <= sh_taken_i;
		end
		if (mul_valid_i) begin
			q_value[mul_ptr] <= mul_value_i;
			q_tag[mul_ptr] <= mul_tag_i;
			q_rob[mul_ptr] <= mul_rob_i;
			q_is_br[mul_ptr] <= 1'b0;
			q_taken[mul_ptr] <= 1'b0;
		end
	end

	// Head retires in the cycle it is shown
	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			cdb_valid_o <= 1'b0;
		end else begin
			if (wb_valid_o)
				head_q <= head_q + 1'b1;
			tail_q <= tail_q + n_wr;
			count_q <= count_q + n_wr - wb_valid_o;
			cdb_valid_o <= preg_wr_en_o;
		end
	end

	always_ff @(posedge clk) begin
		cdb_tag_o <= preg_wr_idx_o; // Broadcast one cycle after the PRF write
	end

	assign wb_valid_o = (count_q != '0);
	assign preg_wr_en_o = wb_valid_o & ~q_is_br[head_q];
	assign preg_wr_idx_o = q_tag[head_q];
	assign preg_wr_value_o = q_value[head_q];
	assign rob_idx_o = q_rob[head_q];
	assign br_taken_o = q_taken[head_q];
	assign br_target_o = q_is_br[head_q] ? q_value[head_q] : '0;
	assign credit_o = wb_valid_o;

endmodule

// File: verilog/fu_cluster.sv
`timescale 1ns/1ps

module fu_cluster (
	input  logic                          clk,
	input  logic                          rst,
	input  fu_pkg::fu_sel_e               fu_sel_i,
	input  logic [fu_pkg::XLEN-1:0]       pc_i,
	input  logic [fu_pkg::INST_W-1:0]     ir_i,
	input  logic [fu_pkg::XLEN-1:0]       ra_value_i,
	input  logic [fu_pkg::XLEN-1:0]       rb_value_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_i,
	input  logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_i,
	output logic                          wb_valid_o,
	output logic                          preg_wr_en_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  preg_wr_idx_o,
	output logic [fu_pkg::XLEN-1:0]       preg_wr_value_o,
	output logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_o,
	output logic                          br_taken_o,
	output logic [fu_pkg::XLEN-1:0]       br_target_o,
	output logic                          credit_o,
	output logic                          cdb_valid_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  cdb_tag_o
);

	logic alu_start, br_start, mul_start;
	fu_pkg::alu_op_e alu_op;
	fu_pkg::br_op_e br_op;
	logic [fu_pkg::XLEN-1:0] opa, opb, npc;
	logic [fu_pkg::DISP_W-1:0] disp;
	logic [fu_pkg::PRF_IDX_W-1:0] dest_tag, alu_tag, mul_tag;
	logic [fu_pkg::ROB_IDX_W-1:0] rob_idx, alu_rob, br_rob, mul_rob;
	logic alu_done, br_done, br_taken, mul_done;
	logic [fu_pkg::XLEN-1:0] alu_result, br_target, mul_product;

	fu_issue_ctrl ctrl0 (
		.clk, .rst, .fu_sel_i, .pc_i, .ir_i, .ra_value_i, .rb_value_i, .dest_tag_i, .rob_idx_i,
		.alu_start_o(alu_start), .br_start_o(br_start), .mul_start_o(mul_start),
		.alu_op_o(alu_op), .br_op_o(br_op), .opa_o(opa), .opb_o(opb), .npc_o(npc),
		.disp_o(disp), .dest_tag_o(dest_tag), .rob_idx_o(rob_idx)
	);

	int_alu alu0 (
		.clk, .rst, .start_i(alu_start), .op_i(alu_op), .opa_i(opa), .opb_i(opb),
		.dest_tag_i(dest_tag), .rob_idx_i(rob_idx), .done_o(alu_done),
		.result_o(alu_result), .dest_tag_o(alu_tag), .rob_idx_o(alu_rob)
	);

	br_alu br0 (
		.clk, .rst, .start_i(br_start), .op_i(br_op), .npc_i(npc), .opa_i(opa),
		.disp_i(disp), .rob_idx_i(rob_idx), .done_o(br_done), .taken_o(br_taken),
		.target_o(br_target), .rob_idx_o(br_rob)
	);

	mult_pipe mul0 (
		.clk, .rst, .start_i(mul_start), .opa_i(opa), .opb_i(opb), .dest_tag_i(dest_tag),
		.rob_idx_i(rob_idx), .done_o(mul_done), .product_o(mul_product),
		.dest_tag_o(mul_tag), .rob_idx_o(mul_rob)
	);

	// ALU and branch never finish together, so one short port serves both
	cmpl_queue cq0 (
		.clk, .rst,
		.sh_valid_i(alu_done | br_done), .sh_is_br_i(br_done),
		.sh_value_i(br_done ? br_target : alu_result), .sh_tag_i(alu_tag),
		.sh_rob_i(br_done ? br_rob : alu_rob), .sh_taken_i(br_done & br_taken),
		.mul_valid_i(mul_done), .mul_value_i(mul_product), .mul_tag_i(mul_tag),
		.mul_rob_i(mul_rob),
		.wb_valid_o, .preg_wr_en_o, .preg_wr_idx_o, .preg_wr_value_o, .rob_idx_o,
		.br_taken_o, .br_target_o, .credit_o, .cdb_valid_o, .cdb_tag_o
	);

endmodule

// File: verilog/fu_issue_ctrl.sv
`timescale 1ns/1ps

module fu_issue_ctrl (
	input  logic                          clk,
	input  logic                          rst,
	input  fu_pkg::fu_sel_e               fu_sel_i,
	input  logic [fu_pkg::XLEN-1:0]       pc_i,
	input  logic [fu_pkg::INST_W-1:0]     ir_i,
	input  logic [fu_pkg::XLEN-1:0]       ra_value_i,
	input  logic [fu_pkg::XLEN-1:0]       rb_value_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_i,
	input  logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_i,
	output logic                          alu_start_o,
	output logic                          br_start_o,
	output logic                          mul_start_o,
	output fu_pkg::alu_op_e               alu_op_o,
	output fu_pkg::br_op_e                br_op_o,
	output logic [fu_pkg::XLEN-1:0]       opa_o,
	output logic [fu_pkg::XLEN-1:0]       opb_o,
	output logic [fu_pkg::XLEN-1:0]       npc_o,
	output logic [fu_pkg::DISP_W-1:0]     disp_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_o,
	output logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_o
);

	logic [fu_pkg::FUNC_W-1:0] func;
	logic [fu_pkg::OPC_W-1:0] opc;
	logic [2:0] unit_en; // {mul, br, alu}
	fu_pkg::alu_op_e alu_op;
	fu_pkg::br_op_e br_op;

	assign func = ir_i[fu_pkg::FUNC_LSB +: fu_pkg::FUNC_W];
	assign opc = ir_i[fu_pkg::OPC_LSB +: fu_pkg::OPC_W];

	always_comb begin
		case (fu_sel_i)
			fu_pkg::FU_SEL_ALU: unit_en = 3'b001;
			fu_pkg::FU_SEL_BR: unit_en = 3'b010;
			fu_pkg::FU_SEL_MULT: unit_en = 3'b100;
			fu_pkg::FU_SEL_LOAD, fu_pkg::FU_SEL_STORE: unit_en = 3'b000; // No memory unit
			default: unit_en = 3'b000;
		endcase
	end

	always_comb begin
		case (func)
			fu_pkg::FUNC_ADDQ: alu_op = fu_pkg::ALU_ADDQ;
			fu_pkg::FUNC_SUBQ: alu_op = fu_pkg::ALU_SUBQ;
			fu_pkg::FUNC_AND: alu_op = fu_pkg::ALU_AND;
			fu_pkg::FUNC_BIS: alu_op = fu_pkg::ALU_BIS;
			fu_pkg::FUNC_XOR: alu_op = fu_pkg::ALU_XOR;
			fu_pkg::FUNC_SLL: alu_op = fu_pkg::ALU_SLL;
			fu_pkg::FUNC_SRL: alu_op = fu_pkg::ALU_SRL;
			fu_pkg::FUNC_CMPEQ: alu_op = fu_pkg::ALU_CMPEQ;
			fu_pkg::FUNC_CMPULT: alu_op = fu_pkg::ALU_CMPULT;
			default: alu_op = fu_pkg::ALU_ADDQ; // Unknown func falls back to add
		endcase
	end

	always_comb begin
		case (opc)
			fu_pkg::OPC_BR: br_op = fu_pkg::BR_ALWAYS;
			fu_pkg::OPC_BEQ: br_op = fu_pkg::BR_EQ;
			fu_pkg::OPC_BNE: br_op = fu_pkg::BR_NE;
			fu_pkg::OPC_BLT: br_op = fu_pkg::BR_LT;
			fu_pkg::OPC_BGE: br_op = fu_pkg::BR_GE;
			default: br_op = fu_pkg::BR_ALWAYS;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			{mul_start_o, br_start_o, alu_start_o} <= 3'b000;
		end else begin
			{mul_start_o, br_start_o, alu_start_o} <= unit_en;
		end
	end

	always_ff @(posedge clk) begin
		alu_op_o <= alu_op;
		br_op_o <= br_op;
		opa_o <= ra_value_i;
		opb_o <= rb_value_i;
		npc_o <= pc_i;
		disp_o <= ir_i[fu_pkg::DISP_W-1:0];
		dest_tag_o <= dest_tag_i;
		rob_idx_o <= rob_idx_i;
	end

endmodule

// File: verilog/fu_pkg.sv
package fu_pkg;

	localparam int XLEN = 64;
	localparam int ROB_IDX_W = 5;
	localparam int PRF_IDX_W = 6;
	localparam int INST_W = 32;

	localparam int CQ_DEPTH = 4; // Also the initial credit count of the RS
	localparam int CQ_PTR_W = 2;

	localparam int MULT_STAGES = 4;
	localparam int MULT_SLICE = XLEN / MULT_STAGES; // Multiplier bits handled per stage

	localparam int OPC_LSB = 26;
	localparam int OPC_W = 6;
	localparam int FUNC_LSB = 5;
	localparam int FUNC_W = 7;
	localparam int DISP_W = 21;

	// Function field codes of the integer ops
	localparam logic [FUNC_W-1:0] FUNC_ADDQ = 7'h20;
	localparam logic [FUNC_W-1:0] FUNC_SUBQ = 7'h29;
	localparam logic [FUNC_W-1:0] FUNC_AND = 7'h00;
	localparam logic [FUNC_W-1:0] FUNC_BIS = 7'h08;
	localparam logic [FUNC_W-1:0] FUNC_XOR = 7'h40;
	localparam logic [FUNC_W-1:0] FUNC_SLL = 7'h39;
	localparam logic [FUNC_W-1:0] FUNC_SRL = 7'h34;
	localparam logic [FUNC_W-1:0] FUNC_CMPEQ = 7'h2d;
	localparam logic [FUNC_W-1:0] FUNC_CMPULT = 7'h1d;

	// Branch opcodes
	localparam logic [OPC_W-1:0] OPC_BR = 6'h30;
	localparam logic [OPC_W-1:0] OPC_BEQ = 6'h39;
	localparam logic [OPC_W-1:0] OPC_BNE = 6'h3d;
	localparam logic [OPC_W-1:0] OPC_BLT = 6'h3a;
	localparam logic [OPC_W-1:0] OPC_BGE = 6'h3e;

	typedef enum logic [2:0] {
		FU_SEL_NONE = 3'd0,
		FU_SEL_ALU = 3'd1,
		FU_SEL_BR = 3'd2,
		FU_SEL_MULT = 3'd3,
		FU_SEL_LOAD = 3'd4,
		FU_SEL_STORE = 3'd5
	} fu_sel_e;

	typedef enum logic [3:0] {
		ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIS, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_CMPEQ, ALU_CMPULT
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_ALWAYS, BR_EQ, BR_NE, BR_LT, BR_GE
	} br_op_e;

endpackage

// File: verilog/int_alu.sv
`timescale 1ns/1ps

module int_alu (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start_i,
	input  fu_pkg::alu_op_e               op_i,
	input  logic [fu_pkg::XLEN-1:0]       opa_i,
	input  logic [fu_pkg::XLEN-1:0]       opb_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_i,
	input  logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_i,
	output logic                          done_o,
	output logic [fu_pkg::XLEN-1:0]       result_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_o,
	output logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_o
);

	logic [fu_pkg::XLEN-1:0] result;
	logic [5:0] shamt;

	assign shamt = opb_i[5:0];

	always_comb begin
		case (op_i)
			fu_pkg::ALU_ADDQ: result = opa_i + opb_i;
			fu_pkg::ALU_SUBQ: result = opa_i - opb_i;
			fu_pkg::ALU_AND: result = opa_i & opb_i;
			fu_pkg::ALU_BIS: result = opa_i | opb_i;
			fu_pkg::ALU_XOR: result = opa_i ^ opb_i;
			fu_pkg::ALU_SLL: result = opa_i << shamt;
			fu_pkg::ALU_SRL: result = opa_i >> shamt; // Logical shift
			fu_pkg::ALU_CMPEQ: result = {{(fu_pkg::XLEN-1){1'b0}}, opa_i == opb_i};
			fu_pkg::ALU_CMPULT: result = {{(fu_pkg::XLEN-1){1'b0}}, opa_i < opb_i};
			default: result = opa_i + opb_i;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
		end
	end

	always_ff @(posedge clk) begin
		result_o <= result;
		dest_tag_o <= dest_tag_i;
		rob_idx_o <= rob_idx_i;
	end

endmodule

// File: verilog/mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start_i,
	input  logic [fu_pkg::XLEN-1:0]       opa_i,
	input  logic [fu_pkg::XLEN-1:0]       opb_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_i,
	input  logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_i,
	output logic                          done_o,
	output logic [fu_pkg::XLEN-1:0]       product_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]  dest_tag_o,
	output logic [fu_pkg::ROB_IDX_W-1:0]  rob_idx_o
);

	logic [fu_pkg::MULT_STAGES-1:0] valid_q;
	logic [fu_pkg::XLEN-1:0] a_q [fu_pkg::MULT_STAGES-1];
	logic [fu_pkg::XLEN-1:0] b_q [fu_pkg::MULT_STAGES-1];
	logic [fu_pkg::XLEN-1:0] acc_q [fu_pkg::MULT_STAGES];
	logic [fu_pkg::PRF_IDX_W-1:0] tag_q [fu_pkg::MULT_STAGES];
	logic [fu_pkg::ROB_IDX_W-1:0] rob_q [fu_pkg::MULT_STAGES];

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[fu_pkg::MULT_STAGES-2:0], start_i};
		end
	end

	// Each stage adds the partial product of one slice of opb
	always_ff @(posedge clk) begin
		a_q[0] <= opa_i;
		b_q[0] <= opb_i;
		acc_q[0] <= opa_i * opb_i[fu_pkg::MULT_SLICE-1:0];
		tag_q[0] <= dest_tag_i;
		rob_q[0] <= rob_idx_i;
		for (int i = 1; i < fu_pkg::MULT_STAGES; i++) begin
			acc_q[i] <= acc_q[i-1] +
				((a_q[i-1] * b_q[i-1][i*fu_pkg::MULT_SLICE +: fu_pkg::MULT_SLICE])
				<< (i*fu_pkg::MULT_SLICE));
			tag_q[i] <= tag_q[i-1];
			rob_q[i] <= rob_q[i-1];
		end
		for (int i = 1; i < fu_pkg::MULT_STAGES - 1; i++) begin
			a_q[i] <= a_q[i-1];
			b_q[i] <= b_q[i-1];
		end
	end

	assign done_o = valid_q[fu_pkg::MULT_STAGES-1];
	assign product_o = acc_q[fu_pkg::MULT_STAGES-1]; // Low 64 bits only
	assign dest_tag_o = tag_q[fu_pkg::MULT_STAGES-1];
	assign rob_idx_o = rob_q[fu_pkg::MULT_STAGES-1];

endmodule
